//--- Bender.yml
package:
  name: tc_core

sources:
  - src/tc_types_pkg.sv
  - src/tc_op_pkg.sv
  - src/tc_decode.sv
  - src/tc_operand_stage.sv
  - src/tc_dot_unit.sv
  - src/tc_result.sv
  - src/tc_core.sv
  - target: simulation
    files:
      - tests/tb_tc_core.sv

//--- build.f
src/tc_types_pkg.sv
src/tc_op_pkg.sv
src/tc_decode.sv
src/tc_operand_stage.sv
src/tc_dot_unit.sv
src/tc_result.sv
src/tc_core.sv
tests/tb_tc_core.sv

//--- src/tc_core.sv
`timescale 1ns/100ps

module tc_core (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                in_valid,
    output logic                                in_ready,
    input  logic [tc_types_pkg::wid_width-1:0]  in_wid,
    input  logic [tc_types_pkg::rd_width-1:0]   in_rd,
    input  tc_op_pkg::mma_step_e                in_step,
    input  tc_op_pkg::pair_pos_e                in_pos,
    input  tc_types_pkg::lane_vec_t             in_rs1,
    input  tc_types_pkg::lane_vec_t             in_rs2,
    input  tc_types_pkg::lane_vec_t             in_rs3,
    output logic                                out_valid,
    input  logic                                out_ready,
    output logic [tc_types_pkg::wid_width-1:0]  out_wid,
    output logic [tc_types_pkg::rd_width-1:0]   out_rd,
    output tc_types_pkg::lane_vec_t             out_data
);
    import tc_types_pkg::*;
    import tc_op_pkg::*;

    // decode to operand stage
    logic                           op_fire;
    logic [wid_width-1:0]           op_wid;
    mma_step_e                      op_step;
    pair_pos_e                      op_pos;

    // operand stage to dot unit
    logic                           hmma_valid;
    logic                           hmma_ready;
    logic [3:0][1:0][word_width-1:0] a_tile;
    logic [1:0][3:0][word_width-1:0] b_tile;
    tile_t                          c_tile;
    logic [wid_width-1:0]           hmma_wid;

    // dot unit to result buffer, and writeback back to decode
    logic                           dpu_valid;
    logic                           dpu_ready;
    tile_t                          dpu_tile;
    logic [wid_width-1:0]           dpu_wid;
    logic                           beat_fire;
    logic [rd_width-1:0]            meta_rd;

    tc_decode u_decode (
        .clk(clk), .reset(reset), .in_valid(in_valid), .in_wid(in_wid), .in_rd(in_rd),
        .in_step(in_step), .in_pos(in_pos), .octet_ready(hmma_ready),
        .beat_fire(beat_fire), .beat_wid(out_wid), .in_ready(in_ready), .op_fire(op_fire),
        .op_wid(op_wid), .op_step(op_step), .op_pos(op_pos), .meta_rd(meta_rd)
    );

    tc_operand_stage u_operand_stage (
        .clk(clk), .reset(reset), .op_fire(op_fire), .in_wid(op_wid), .in_step(op_step),
        .in_pos(op_pos), .in_rs1(in_rs1), .in_rs2(in_rs2), .in_rs3(in_rs3),
        .hmma_valid(hmma_valid), .a_tile(a_tile), .b_tile(b_tile), .c_tile(c_tile),
        .hmma_wid(hmma_wid)
    );

    tc_dot_unit u_dot_unit (
        .clk(clk), .reset(reset), .hmma_valid(hmma_valid), .a_tile(a_tile),
        .b_tile(b_tile), .c_tile(c_tile), .hmma_wid(hmma_wid), .dpu_ready(dpu_ready),
        .hmma_ready(hmma_ready), .dpu_valid(dpu_valid), .dpu_tile(dpu_tile),
        .dpu_wid(dpu_wid)
    );

    tc_result u_result (
        .clk(clk), .reset(reset), .dpu_valid(dpu_valid), .dpu_tile(dpu_tile),
        .dpu_wid(dpu_wid), .out_ready(out_ready), .meta_rd(meta_rd), .dpu_ready(dpu_ready),
        .out_valid(out_valid), .out_wid(out_wid), .out_rd(out_rd), .out_data(out_data),
        .beat_fire(beat_fire)
    );

endmodule

//--- src/tc_decode.sv
`timescale 1ns/100ps

module tc_decode (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                in_valid,
    input  logic [tc_types_pkg::wid_width-1:0]  in_wid,
    input  logic [tc_types_pkg::rd_width-1:0]   in_rd,
    input  tc_op_pkg::mma_step_e                in_step,
    input  tc_op_pkg::pair_pos_e                in_pos,
    input  logic                                octet_ready,
    input  logic                                beat_fire,
    input  logic [tc_types_pkg::wid_width-1:0]  beat_wid,
    output logic                                in_ready,
    output logic                                op_fire,
    output logic [tc_types_pkg::wid_width-1:0]  op_wid,
    output tc_op_pkg::mma_step_e                op_step,
    output tc_op_pkg::pair_pos_e                op_pos,
    output logic [tc_types_pkg::rd_width-1:0]   meta_rd
);
    import tc_types_pkg::*;

    // per-warp rd queues with one entry per accepted instruction
    logic [rd_width-1:0] queue_mem [num_warps][meta_depth];
    logic [num_warps-1:0][$clog2(meta_depth)-1:0] wr_ptr;
    logic [num_warps-1:0][$clog2(meta_depth)-1:0] rd_ptr;
    logic [num_warps-1:0][$clog2(meta_depth+1)-1:0] count;
    logic [num_warps-1:0] push;
    logic [num_warps-1:0] pop;
    logic [num_warps-1:0] full;
    logic [num_warps-1:0] empty;
    logic any_full;
    logic valid_synced;

    always_comb begin
        for (int w = 0; w < num_warps; w++) begin
            push[w]  = op_fire && (in_wid == wid_width'(w));
            pop[w]   = beat_fire && (beat_wid == wid_width'(w));
            full[w]  = (count[w] == meta_depth);
            empty[w] = (count[w] == 0);
        end
    end

    // any full queue blocks every warp so queues and octet stay in step
    assign any_full     = |full;
    assign valid_synced = in_valid && !any_full;
    assign in_ready     = octet_ready && !any_full;
    assign op_fire      = valid_synced && octet_ready;

    // instruction fields handed on to the operand stage
    assign op_wid  = in_wid;
    assign op_step = in_step;
    assign op_pos  = in_pos;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            for (int w = 0; w < num_warps; w++) begin
                if (push[w]) begin
                    wr_ptr[w] <= wr_ptr[w] + 1'b1;
                end
                if (pop[w]) begin
                    rd_ptr[w] <= rd_ptr[w] + 1'b1;
                end
                if (push[w] && !pop[w]) begin
                    count[w] <= count[w] + 1'b1;
                end else if (pop[w] && !push[w]) begin
                    count[w] <= count[w] - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op_fire) begin
            queue_mem[in_wid][wr_ptr[in_wid]] <= in_rd;
        end
    end

    // head of the retiring warp gives the first rd on beat_lo and the last on beat_hi
    assign meta_rd = queue_mem[beat_wid][rd_ptr[beat_wid]];

    // every writeback beat must find an rd queued for its warp
    a_queue_bounds: assert property (@(posedge clk) disable iff (reset)
        (pop & empty) == '0);

endmodule

//--- src/tc_dot_unit.sv
`timescale 1ns/100ps

module tc_dot_unit (
    input  logic                                            clk,
    input  logic                                            reset,
    input  logic                                            hmma_valid,
    input  logic [3:0][1:0][tc_types_pkg::word_width-1:0]   a_tile,
    input  logic [1:0][3:0][tc_types_pkg::word_width-1:0]   b_tile,
    input  tc_types_pkg::tile_t                             c_tile,
    input  logic [tc_types_pkg::wid_width-1:0]              hmma_wid,
    input  logic                                            dpu_ready,
    output logic                                            hmma_ready,
    output logic                                            dpu_valid,
    output tc_types_pkg::tile_t                             dpu_tile,
    output logic [tc_types_pkg::wid_width-1:0]              dpu_wid
);
    import tc_types_pkg::*;

    // stage one holds the eight-by-four products plus C
    logic                                       s1_valid;
    logic [3:0][3:0][1:0][word_width-1:0]       s1_prod;
    tile_t                                      s1_c;
    logic [wid_width-1:0]                       s1_wid;
    logic                                       advance;

    // whole pipe moves together, a held output freezes both stages
    assign advance    = !dpu_valid || dpu_ready;
    assign hmma_ready = advance;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            dpu_valid <= 1'b0;
        end else if (advance) begin
            s1_valid  <= hmma_valid;
            dpu_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    for (int k = 0; k < 2; k++) begin
                        // low word of the product only
                        s1_prod[i][j][k] <= a_tile[i][k] * b_tile[k][j];
                    end
                    // reduce over k and accumulate onto C
                    dpu_tile[i][j] <= s1_prod[i][j][0] + s1_prod[i][j][1] + s1_c[i][j];
                end
            end
            s1_c    <= c_tile;
            s1_wid  <= hmma_wid;
            dpu_wid <= s1_wid;
        end
    end

    // decode must never issue into a stalled pipe
    a_no_issue_stalled: assert property (@(posedge clk) disable iff (reset)
        hmma_valid |-> hmma_ready);

endmodule

//--- src/tc_op_pkg.sv
package tc_op_pkg;

    // step selects which halves of A and B a pair works on
    typedef enum logic [1:0] {
        step_0 = 2'd0,
        step_1 = 2'd1,
        step_2 = 2'd2,
        step_3 = 2'd3
    } mma_step_e;

    // position of an instruction inside its pair
    typedef enum logic {
        pair_first = 1'b0,
        pair_last  = 1'b1
    } pair_pos_e;

    // writeback beat, lo carries columns 0/2 and hi columns 1/3
    typedef enum logic {
        beat_lo = 1'b0,
        beat_hi = 1'b1
    } wb_beat_e;

endpackage

//--- src/tc_operand_stage.sv
`timescale 1ns/100ps

module tc_operand_stage (
    input  logic                                                clk,
    input  logic                                                reset,
    input  logic                                                op_fire,
    input  logic [tc_types_pkg::wid_width-1:0]                  in_wid,
    input  tc_op_pkg::mma_step_e                                in_step,
    input  tc_op_pkg::pair_pos_e                                in_pos,
    input  tc_types_pkg::lane_vec_t                             in_rs1,
    input  tc_types_pkg::lane_vec_t                             in_rs2,
    input  tc_types_pkg::lane_vec_t                             in_rs3,
    output logic                                                hmma_valid,
    output logic [3:0][1:0][tc_types_pkg::word_width-1:0]       a_tile,
    output logic [1:0][3:0][tc_types_pkg::word_width-1:0]       b_tile,
    output tc_types_pkg::tile_t                                 c_tile,
    output logic [tc_types_pkg::wid_width-1:0]                  hmma_wid
);
    import tc_types_pkg::*;
    import tc_op_pkg::*;

    // half tiles picked out of the current instruction
    logic [3:0][word_width-1:0] a_half;
    logic [3:0][word_width-1:0] b_half;

    // first halves waiting per warp for their partner
    logic [num_warps-1:0][3:0][word_width-1:0] a_buf;
    logic [num_warps-1:0][3:0][word_width-1:0] b_buf;
    logic [num_warps-1:0][num_lanes-1:0][word_width-1:0] c_buf;
    logic first_fire;

    // A takes a 2x2 subtile from each threadgroup, column pair set by step[0]
    // B is shared by both threadgroups, lane group set by step[1]
    always_comb begin
        case (in_step)
            step_1, step_3: a_half = {in_rs1[tg_lane_offset+2 +: 2], in_rs1[2 +: 2]};
            default:        a_half = {in_rs1[tg_lane_offset +: 2], in_rs1[0 +: 2]};
        endcase
        case (in_step)
            step_2, step_3: b_half = in_rs2[tg_lane_offset +: 4];
            default:        b_half = in_rs2[0 +: 4];
        endcase
    end

    assign first_fire = op_fire && (in_pos == pair_first);
    assign hmma_valid = op_fire && (in_pos == pair_last);
    assign hmma_wid   = in_wid;

    // cleared so a last half without a partner sees zeros
    always_ff @(posedge clk) begin
        if (reset) begin
            a_buf <= '0;
            b_buf <= '0;
            c_buf <= '0;
        end else if (first_fire) begin
            a_buf[in_wid] <= a_half;
            b_buf[in_wid] <= b_half;
            c_buf[in_wid] <= in_rs3;
        end
    end

    // k=0 comes from the buffer, k=1 from the operand bus
    // C uses the jagged 1x2 layout, each lane owns two adjacent columns
    always_comb begin
        int lane;
        for (int r = 0; r < 4; r++) begin
            a_tile[r][0] = a_buf[in_wid][r];
            a_tile[r][1] = a_half[r];
        end
        b_tile[0] = b_buf[in_wid];
        b_tile[1] = b_half;
        for (int r = 0; r < 4; r++) begin
            // rows 0,1 from lanes 0..3, rows 2,3 from the second threadgroup
            lane = (r / 2) * tg_lane_offset + (r % 2);
            c_tile[r][0] = c_buf[in_wid][lane];
            c_tile[r][1] = in_rs3[lane];
            c_tile[r][2] = c_buf[in_wid][lane + 2];
            c_tile[r][3] = in_rs3[lane + 2];
        end
    end

endmodule

//--- src/tc_result.sv
`timescale 1ns/100ps

module tc_result (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                dpu_valid,
    input  tc_types_pkg::tile_t                 dpu_tile,
    input  logic [tc_types_pkg::wid_width-1:0]  dpu_wid,
    input  logic                                out_ready,
    input  logic [tc_types_pkg::rd_width-1:0]   meta_rd,
    output logic                                dpu_ready,
    output logic                                out_valid,
    output logic [tc_types_pkg::wid_width-1:0]  out_wid,
    output logic [tc_types_pkg::rd_width-1:0]   out_rd,
    output tc_types_pkg::lane_vec_t             out_data,
    output logic                                beat_fire
);
    import tc_types_pkg::*;
    import tc_op_pkg::*;

    // small fifo of finished tiles, decouples dpu bursts from writeback
    tile_t                              buf_tile [result_depth];
    logic [wid_width-1:0]               buf_wid [result_depth];
    logic [$clog2(result_depth)-1:0]    wr_ptr;
    logic [$clog2(result_depth)-1:0]    rd_ptr;
    logic [$clog2(result_depth+1)-1:0]  count;
    logic                               full;
    logic                               push;
    logic                               pop;
    wb_beat_e                           beat;
    tile_t                              head_tile;
    logic [1:0]                         col;

    assign full      = (count == result_depth);
    assign dpu_ready = !full;
    assign push      = dpu_valid && dpu_ready;
    assign out_valid = (count != 0);
    assign beat_fire = out_valid && out_ready;
    // entry retires only after its second beat
    assign pop       = beat_fire && (beat == beat_hi);

    assign head_tile = buf_tile[rd_ptr];
    assign out_wid   = buf_wid[rd_ptr];
    assign out_rd    = meta_rd;

    // beat_lo writes columns 0 and 2, beat_hi columns 1 and 3
    always_comb begin
        col = (beat == beat_hi) ? 2'd1 : 2'd0;
        for (int g = 0; g < 2; g++) begin
            out_data[g*tg_lane_offset + 0] = head_tile[2*g][col];
            out_data[g*tg_lane_offset + 1] = head_tile[2*g + 1][col];
            out_data[g*tg_lane_offset + 2] = head_tile[2*g][col + 2'd2];
            out_data[g*tg_lane_offset + 3] = head_tile[2*g + 1][col + 2'd2];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            beat   <= beat_lo;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
            // one subcommit bit is enough, writeback finishes one tile at a time
            if (beat_fire) begin
                beat <= (beat == beat_lo) ? beat_hi : beat_lo;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            buf_tile[wr_ptr] <= dpu_tile;
            buf_wid[wr_ptr]  <= dpu_wid;
        end
    end

    // a tile refused while full stays offered unchanged, nothing is dropped
    a_no_push_full: assert property (@(posedge clk) disable iff (reset)
        dpu_valid && full |=> dpu_valid && $stable(dpu_tile) && $stable(dpu_wid));

endmodule

//--- src/tc_types_pkg.sv
package tc_types_pkg;

    // one octet serves eight lanes, two threadgroups of four
    localparam int num_lanes = 8;

    // integer datapath, all sums wrap at this width
    localparam int word_width = 32;

    // warps that can hold a half pair in flight at once
    localparam int num_warps = 2;
    localparam int wid_width = 1;

    // destination register index carried for writeback
    localparam int rd_width = 5;

    // second threadgroup starts at this lane
    localparam int tg_lane_offset = 4;

    // rd entries kept per warp until both beats retire
    localparam int meta_depth = 4;

    // finished tiles waiting for the two writeback beats
    localparam int result_depth = 2;

    // one word per lane, as seen on the register ports
    typedef logic [num_lanes-1:0][word_width-1:0] lane_vec_t;

    // 4x4 row-major tile, indexed [row][col]
    typedef logic [3:0][3:0][word_width-1:0] tile_t;

endpackage

//--- tests/tb_tc_core.sv
`timescale 1ns/100ps

module tb_tc_core;
    import tc_types_pkg::*;
    import tc_op_pkg::*;

    // watchdog budget is the sum of the reset and per-test cycle allowances
    localparam int budget_cycles = 20 + 10 + 200 + 100 + 200 + 300;
    // A half lanes for each column pair and the first C lane of each row
    localparam int a_lanes_lo[4] = '{0, 1, 4, 5};
    localparam int a_lanes_hi[4] = '{2, 3, 6, 7};
    localparam int c_lane[4] = '{0, 1, 4, 5};

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic in_valid = 1'b0;
    logic in_ready;
    logic [wid_width-1:0] in_wid = '0;
    logic [rd_width-1:0] in_rd = '0;
    mma_step_e in_step = step_0;
    pair_pos_e in_pos = pair_first;
    lane_vec_t in_rs1 = '0;
    lane_vec_t in_rs2 = '0;
    lane_vec_t in_rs3 = '0;
    logic out_valid;
    logic out_ready = 1'b1;
    logic [wid_width-1:0] out_wid;
    logic [rd_width-1:0] out_rd;
    lane_vec_t out_data;

    logic [31:0] rng = 32'hf6aa_679c;
    int num_tests = 0;
    int num_checks = 0;
    int num_errors = 0;
    int errors_at_start = 0;
    // model copy of each warp's buffered first half
    mma_step_e f_step [num_warps];
    lane_vec_t f_rs1 [num_warps];
    lane_vec_t f_rs2 [num_warps];
    lane_vec_t f_rs3 [num_warps];
    logic [rd_width-1:0] f_rd [num_warps];
    // predicted beats in writeback order
    lane_vec_t exp_data [$];
    logic [wid_width-1:0] exp_wid [$];
    logic [rd_width-1:0] exp_rd [$];
    // stalled beat that must hold until it transfers
    logic held_valid = 1'b0;
    lane_vec_t held_data;

    tc_core dut (
        .clk(clk), .reset(reset), .in_valid(in_valid), .in_ready(in_ready), .in_wid(in_wid),
        .in_rd(in_rd), .in_step(in_step), .in_pos(in_pos), .in_rs1(in_rs1), .in_rs2(in_rs2),
        .in_rs3(in_rs3), .out_valid(out_valid), .out_ready(out_ready), .out_wid(out_wid),
        .out_rd(out_rd), .out_data(out_data)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic lane_vec_t random_lanes();
        lane_vec_t v;
        for (int l = 0; l < num_lanes; l++) begin
            rng = xorshift32(rng);
            v[l] = rng;
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [255:0] expected,
                               input logic [255:0] actual);
        num_checks++;
        assert (actual === expected) else begin
            $display("mismatch at %0t: %s expected %0h got %0h", $time, name, expected, actual);
            num_errors++;
        end
    endtask

    // model of a whole pair from half selection through D = A*B + C to the jagged beats
    task automatic predict_pair(input int w, input mma_step_e s, input lane_vec_t r1,
                                input lane_vec_t r2, input lane_vec_t r3,
                                input logic [rd_width-1:0] rd);
        logic [3:0][1:0][word_width-1:0] a;
        logic [1:0][3:0][word_width-1:0] b;
        tile_t c;
        tile_t d;
        lane_vec_t lo;
        lane_vec_t hi;
        for (int r = 0; r < 4; r++) begin
            a[r][0] = (f_step[w] inside {step_1, step_3}) ? f_rs1[w][a_lanes_hi[r]]
                                                          : f_rs1[w][a_lanes_lo[r]];
            a[r][1] = (s inside {step_1, step_3}) ? r1[a_lanes_hi[r]] : r1[a_lanes_lo[r]];
            b[0][r] = (f_step[w] inside {step_2, step_3}) ? f_rs2[w][4 + r] : f_rs2[w][r];
            b[1][r] = (s inside {step_2, step_3}) ? r2[4 + r] : r2[r];
            c[r][0] = f_rs3[w][c_lane[r]];
            c[r][1] = r3[c_lane[r]];
            c[r][2] = f_rs3[w][c_lane[r] + 2];
            c[r][3] = r3[c_lane[r] + 2];
        end
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                d[i][j] = a[i][0] * b[0][j] + a[i][1] * b[1][j] + c[i][j];
            end
        end
        // lanes 0..3 carry rows 0,1 and lanes 4..7 rows 2,3
        for (int g = 0; g < 2; g++) begin
            lo[4*g + 0] = d[2*g][0];
            lo[4*g + 1] = d[2*g + 1][0];
            lo[4*g + 2] = d[2*g][2];
            lo[4*g + 3] = d[2*g + 1][2];
            hi[4*g + 0] = d[2*g][1];
            hi[4*g + 1] = d[2*g + 1][1];
            hi[4*g + 2] = d[2*g][3];
            hi[4*g + 3] = d[2*g + 1][3];
        end
        exp_data.push_back(lo);
        exp_wid.push_back(wid_width'(w));
        exp_rd.push_back(f_rd[w]);
        exp_data.push_back(hi);
        exp_wid.push_back(wid_width'(w));
        exp_rd.push_back(rd);
    endtask

    // one instruction with random operands held until accepted
    task automatic send_instr(input int w, input logic [rd_width-1:0] rd, input mma_step_e s,
                              input pair_pos_e p);
        @(negedge clk);
        in_valid = 1'b1;
        in_wid = wid_width'(w);
        in_rd = rd;
        in_step = s;
        in_pos = p;
        in_rs1 = random_lanes();
        in_rs2 = random_lanes();
        in_rs3 = random_lanes();
        #1;
        while (!in_ready) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);
        if (p == pair_first) begin
            f_step[w] = s;
            f_rs1[w] = in_rs1;
            f_rs2[w] = in_rs2;
            f_rs3[w] = in_rs3;
            f_rd[w] = rd;
        end else begin
            predict_pair(w, s, in_rs1, in_rs2, in_rs3, rd);
        end
    endtask

    task automatic send_pair(input int w, input logic [rd_width-1:0] rd, input mma_step_e s);
        send_instr(w, rd, s, pair_first);
        send_instr(w, rd + 1'b1, s, pair_last);
    endtask

    task automatic drain_results();
        @(negedge clk);
        in_valid = 1'b0;
        out_ready = 1'b1;
        while (exp_data.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic finish_test(input string name);
        num_tests++;
        $display("test %s finished with %0d errors", name, num_errors - errors_at_start);
        errors_at_start = num_errors;
    endtask

    // every out transfer is compared with the oldest predicted beat
    always @(posedge clk) begin
        if (!reset && out_valid) begin
            if (held_valid) begin
                check_value("out_data (stalled)", held_data, out_data);
            end
            if (out_ready) begin
                held_valid = 1'b0;
                if (exp_data.size() == 0) begin
                    $display("writeback beat at %0t with no result predicted", $time);
                    num_errors++;
                end else begin
                    check_value("out_data", exp_data.pop_front(), out_data);
                    check_value("out_wid", exp_wid.pop_front(), out_wid);
                    check_value("out_rd", exp_rd.pop_front(), out_rd);
                end
            end else begin
                held_valid = 1'b1;
                held_data = out_data;
            end
        end else begin
            // a stalled beat may not be withdrawn before it transfers
            assert (!held_valid) else begin
                $display("out_valid dropped at %0t while a beat was stalled", $time);
                num_errors++;
            end
            held_valid = 1'b0;
        end
    end

    task automatic check_after_reset();
        @(negedge clk);
        #1;
        check_value("out_valid", 1'b0, out_valid);
        check_value("in_ready", 1'b1, in_ready);
        finish_test("reset state");
    endtask

    task automatic run_each_step();
        send_pair(0, 5'd2, step_0);
        send_pair(0, 5'd4, step_1);
        send_pair(0, 5'd6, step_2);
        send_pair(0, 5'd8, step_3);
        drain_results();
        finish_test("single steps");
    endtask

    // warp 1 completes first while each warp keeps its own buffered half
    task automatic interleave_warps();
        send_instr(0, 5'd10, step_1, pair_first);
        send_instr(1, 5'd20, step_2, pair_first);
        send_instr(1, 5'd21, step_3, pair_last);
        send_instr(0, 5'd11, step_0, pair_last);
        drain_results();
        finish_test("interleaved warps");
    endtask

    task automatic stall_writeback();
        logic dropped;
        logic seen;
        @(negedge clk);
        out_ready = 1'b0;
        send_pair(0, 5'd12, step_2);
        send_pair(1, 5'd14, step_1);
        send_pair(0, 5'd16, step_3);
        @(negedge clk);
        in_valid = 1'b0;
        dropped = 1'b0;
        seen = 1'b0;
        for (int i = 0; i < 20 && !(dropped && seen); i++) begin
            @(negedge clk);
            #1;
            dropped = dropped || !in_ready;
            seen = seen || out_valid;
        end
        assert (dropped) else begin
            $display("in_ready stayed high while writeback was stalled");
            num_errors++;
        end
        assert (seen) else begin
            $display("no result became valid while writeback was stalled");
            num_errors++;
        end
        // keep the stall a while so the held beat is compared several times
        repeat (5) @(negedge clk);
        drain_results();
        finish_test("back-pressure");
    endtask

    task automatic stream_pairs();
        for (int n = 0; n < 6; n++) begin
            rng = xorshift32(rng);
            send_pair(n % 2, 5'(2 * n + 1), mma_step_e'(rng[1:0]));
        end
        drain_results();
        finish_test("back-to-back pairs");
    endtask

    initial begin
        #(budget_cycles * 100);
        $display("timeout: the tests did not finish within %0d cycles", budget_cycles);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_after_reset();
        run_each_step();
        interleave_warps();
        stall_writeback();
        stream_pairs();
        $display("tests %0d, checks %0d, errors %0d", num_tests, num_checks, num_errors);
        if (num_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
